/* Bender.yml */
package:
  name: maple_sniffer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/maple_pkg.sv
      - src/maple_byte_if.sv
      - src/maple_line_rx.sv
      - src/maple_header_check.sv
      - src/maple_button_capture.sv
      - src/maple_ctrl_regs.sv
      - src/maple_top.sv
  - target: test
    include_dirs:
      - include
      - dv
    files:
      - dv/maple_tb.sv

/* dv/maple_bus_tasks.svh */
`ifndef MAPLE_BUS_TASKS_SVH
`define MAPLE_BUS_TASKS_SVH

// sender side of the Maple pins, included inside the testbench module
// a level changes on a rising edge and stays for line_hold clocks

task automatic set_lines(input logic p1, input logic p5);
    @(posedge clk);
    pin1 <= p1;
    pin5 <= p5;
    repeat (line_hold - 1) @(posedge clk);
endtask

// pin1 low, four pin5 pulses, pin1 back high
task automatic send_start();
    int i;
    set_lines(1'b1, 1'b1);
    set_lines(1'b0, 1'b1);
    for (i = 0; i < 4; i++) begin
        set_lines(1'b0, 1'b0);
        set_lines(1'b0, 1'b1);
    end
    set_lines(1'b1, 1'b1);
endtask

// pin5 holds the bit while pin1 falls
task automatic send_bit_on_pin1(input logic b);
    set_lines(1'b1, b);
    set_lines(1'b0, b);
    set_lines(1'b0, 1'b1);  // pin5 up again for its own clock
endtask

// pin1 holds the bit while pin5 falls
task automatic send_bit_on_pin5(input logic b);
    set_lines(b, 1'b1);
    set_lines(b, 1'b0);
    set_lines(1'b1, 1'b0);
endtask

// MSB first, the first bit of every byte is clocked by pin1
task automatic send_byte(input maple_byte_t value);
    int i;
    for (i = 7; i >= 0; i--) begin
        if (i % 2 == 1) begin
            send_bit_on_pin1(value[i]);
        end else begin
            send_bit_on_pin5(value[i]);
        end
    end
endtask

// pin5 stays low, two pin1 falls, then both lines released
task automatic send_end();
    set_lines(1'b0, 1'b0);
    set_lines(1'b1, 1'b0);
    set_lines(1'b0, 1'b0);
    set_lines(1'b1, 1'b0);  // frame_end follows this rise
    set_lines(1'b1, 1'b1);
endtask

`endif

/* dv/maple_tb.sv */
`timescale 1ns/1ps
`include "maple_settings.svh"

module maple_tb import maple_pkg::*; ();

    localparam int line_hold   = 5;     // clocks per pin level
    localparam int frame_len   = 16;    // header, payload and stick bytes
    localparam int ready_limit = 8;
    localparam int poll_limit  = 40;

    logic             clk;
    logic             reset;
    logic             pin1;
    logic             pin5;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [3:0]       paddr;
    logic [31:0]      pwdata;
    logic [31:0]      prdata;
    logic             pready;
    logic             pslverr;
    controller_data_t controller_data;

    integer           seed;
    maple_byte_t      frame_bytes [0:frame_len-1];
    controller_data_t exp_state;    // model of the published state
    count_t           exp_good;
    count_t           exp_reject;
    logic [31:0]      rd_word;      // last APB result
    logic             rd_err;

    `include "maple_bus_tasks.svh"

    maple_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_state(input string name, input controller_data_t got,
                               input controller_data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // read data above the register width must be zero
    task automatic check_zero_ext(input string name, input logic [31:0] word,
                                  input int width);
        logic [31:0] upper;
        upper = word >> width;
        if (upper !== 32'h0) begin
            stop_on_error($sformatf("Fail: %s = 0x%h, expected 0x0", name, upper));
        end
    endtask

    // one APB transfer through setup and access phase
    task automatic apb_access(input logic [3:0] addr, input logic write,
                              input logic [31:0] wdata);
        int waits;
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            if (waits == ready_limit) begin
                stop_on_error("APB access did not complete, pready stayed low");
            end
            waits++;
            @(negedge clk);
        end
        rd_word = prdata;
        rd_err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // port and all three registers against the model
    task automatic check_regs();
        check_state("controller_data", controller_data, exp_state);
        apb_access(`MAPLE_ADDR_STATE, 1'b0, 32'h0);
        check_err("pslverr at 0x0", rd_err, 1'b0);
        check_state("prdata at 0x0", controller_data_t'(rd_word), exp_state);
        check_zero_ext("prdata upper bits at 0x0", rd_word, $bits(controller_data_t));
        apb_access(`MAPLE_ADDR_GOOD, 1'b0, 32'h0);
        check_err("pslverr at 0x4", rd_err, 1'b0);
        check_count("good count", count_t'(rd_word), exp_good);
        check_zero_ext("prdata upper bits at 0x4", rd_word, $bits(count_t));
        apb_access(`MAPLE_ADDR_REJECT, 1'b0, 32'h0);
        check_err("pslverr at 0x8", rd_err, 1'b0);
        check_count("rejected count", count_t'(rd_word), exp_reject);
        check_zero_ext("prdata upper bits at 0x8", rd_word, $bits(count_t));
    endtask

    task automatic model_frame();
        controller_data_t cd;
        logic             trig_full;
        cd = '0;
        if (frame_bytes[`MAPLE_POS_WORDS] == `MAPLE_WORDS_VAL &&
            frame_bytes[`MAPLE_POS_RECIP] == `MAPLE_RECIP_VAL &&
            frame_bytes[`MAPLE_POS_CMD] == `MAPLE_CMD_VAL &&
            frame_bytes[`MAPLE_POS_FUNC] == `MAPLE_FUNC_VAL) begin
            cd[`MAPLE_CD_VALID] = 1'b1;
            cd[`MAPLE_CD_LTRIG] = (frame_bytes[`MAPLE_POS_LTRIG] == `MAPLE_TRIG_FULL);
            cd[`MAPLE_CD_RTRIG] = (frame_bytes[`MAPLE_POS_RTRIG] == `MAPLE_TRIG_FULL);
            cd[`MAPLE_CD_Y]     = ~frame_bytes[`MAPLE_POS_BTN_HI][1];  // buttons active low
            cd[`MAPLE_CD_X]     = ~frame_bytes[`MAPLE_POS_BTN_HI][2];
            cd[`MAPLE_CD_B]     = ~frame_bytes[`MAPLE_POS_BTN_LO][1];
            cd[`MAPLE_CD_A]     = ~frame_bytes[`MAPLE_POS_BTN_LO][2];
            cd[`MAPLE_CD_START] = ~frame_bytes[`MAPLE_POS_BTN_LO][3];
            cd[`MAPLE_CD_UP]    = ~frame_bytes[`MAPLE_POS_BTN_LO][4];
            cd[`MAPLE_CD_DOWN]  = ~frame_bytes[`MAPLE_POS_BTN_LO][5];
            cd[`MAPLE_CD_LEFT]  = ~frame_bytes[`MAPLE_POS_BTN_LO][6];
            cd[`MAPLE_CD_RIGHT] = ~frame_bytes[`MAPLE_POS_BTN_LO][7];
            trig_full = cd[`MAPLE_CD_LTRIG] & cd[`MAPLE_CD_RTRIG];
            cd[`MAPLE_CD_OSD] = trig_full &&
                frame_bytes[`MAPLE_POS_BTN_HI] == `MAPLE_HOT_X &&
                frame_bytes[`MAPLE_POS_BTN_LO] == `MAPLE_HOT_A_START;
            cd[`MAPLE_CD_DEFRES] = trig_full &&
                frame_bytes[`MAPLE_POS_BTN_HI] == `MAPLE_HOT_Y &&
                frame_bytes[`MAPLE_POS_BTN_LO] == `MAPLE_HOT_B_START;
            exp_state = cd;
            exp_good++;
        end else begin
            exp_reject++;   // state stays as it was
        end
    endtask

    task automatic set_payload(input maple_byte_t ltrig, input maple_byte_t rtrig,
                               input maple_byte_t btn_hi, input maple_byte_t btn_lo);
        frame_bytes[`MAPLE_POS_LTRIG]  = ltrig;
        frame_bytes[`MAPLE_POS_RTRIG]  = rtrig;
        frame_bytes[`MAPLE_POS_BTN_HI] = btn_hi;
        frame_bytes[`MAPLE_POS_BTN_LO] = btn_lo;
    endtask

    // kind 0 random buttons, 1 osd hotkey, 2 resolution hotkey, 3 X with B+start
    task automatic build_frame(input logic good, input int kind);
        int          i;
        int          bad_pos;
        maple_byte_t flip;
        for (i = 0; i < frame_len; i++) begin
            frame_bytes[i] = $random(seed);
        end
        frame_bytes[`MAPLE_POS_WORDS] = `MAPLE_WORDS_VAL;
        frame_bytes[`MAPLE_POS_RECIP] = `MAPLE_RECIP_VAL;
        frame_bytes[`MAPLE_POS_CMD]   = `MAPLE_CMD_VAL;
        frame_bytes[`MAPLE_POS_FUNC]  = `MAPLE_FUNC_VAL;
        case (kind)
            1: set_payload(`MAPLE_TRIG_FULL, `MAPLE_TRIG_FULL, `MAPLE_HOT_X, `MAPLE_HOT_A_START);
            2: set_payload(`MAPLE_TRIG_FULL, `MAPLE_TRIG_FULL, `MAPLE_HOT_Y, `MAPLE_HOT_B_START);
            3: set_payload(`MAPLE_TRIG_FULL, `MAPLE_TRIG_FULL, `MAPLE_HOT_X, `MAPLE_HOT_B_START);
            default: begin
                // triggers fully pressed about half the time
                if ($random(seed) & 1) begin
                    frame_bytes[`MAPLE_POS_LTRIG] = `MAPLE_TRIG_FULL;
                end
                if ($random(seed) & 1) begin
                    frame_bytes[`MAPLE_POS_RTRIG] = `MAPLE_TRIG_FULL;
                end
            end
        endcase
        if (!good) begin
            case ($random(seed) & 3)
                0: bad_pos = `MAPLE_POS_WORDS;
                1: bad_pos = `MAPLE_POS_RECIP;
                2: bad_pos = `MAPLE_POS_CMD;
                default: bad_pos = `MAPLE_POS_FUNC;
            endcase
            flip = $random(seed);
            frame_bytes[bad_pos] = frame_bytes[bad_pos] ^ (flip | 8'h01);
        end
    endtask

    // counters move in the clock after frame_end
    task automatic wait_for_result();
        count_t seen;
        int     polls;
        polls = 0;
        seen  = '0;
        while (seen != exp_good + exp_reject) begin
            if (polls == poll_limit) begin
                stop_on_error("frame was never counted after its end pattern");
            end
            polls++;
            apb_access(`MAPLE_ADDR_GOOD, 1'b0, 32'h0);
            seen = count_t'(rd_word);
            apb_access(`MAPLE_ADDR_REJECT, 1'b0, 32'h0);
            seen = seen + count_t'(rd_word);
        end
    endtask

    task automatic run_frame();
        int i;
        model_frame();
        send_start();
        for (i = 0; i < frame_len; i++) begin
            send_byte(frame_bytes[i]);
        end
        send_end();
        wait_for_result();
        check_regs();
    endtask

    initial begin
        int n;
        seed       = 61281;
        reset      = 1'b1;
        pin1       = 1'b1;  // idle bus
        pin5       = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 4'h0;
        pwdata     = 32'h0;
        exp_state  = '0;
        exp_good   = '0;
        exp_reject = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        check_regs();
        build_frame(1'b1, 0);
        run_frame();
        build_frame(1'b0, 0);   // one header byte broken
        run_frame();
        build_frame(1'b1, 1);
        run_frame();
        build_frame(1'b1, 2);
        run_frame();
        build_frame(1'b1, 3);
        run_frame();

        // registers are read only and unknown addresses are refused
        apb_access(`MAPLE_ADDR_STATE, 1'b1, $random(seed));
        check_err("pslverr on write to 0x0", rd_err, 1'b1);
        apb_access(`MAPLE_ADDR_GOOD, 1'b1, $random(seed));
        check_err("pslverr on write to 0x4", rd_err, 1'b1);
        apb_access(`MAPLE_ADDR_REJECT, 1'b1, $random(seed));
        check_err("pslverr on write to 0x8", rd_err, 1'b1);
        apb_access(4'hC, 1'b0, 32'h0);
        check_err("pslverr on read of 0xC", rd_err, 1'b1);
        check_regs();

        for (n = 0; n < 40; n++) begin
            build_frame(($random(seed) & 3) != 0, ($random(seed) & 3));
            run_frame();
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

/* include/maple_settings.svh */
`ifndef MAPLE_SETTINGS_SVH
`define MAPLE_SETTINGS_SVH

// header of a controller data reply
`define MAPLE_WORDS_VAL     8'h03   // three words follow the header
`define MAPLE_RECIP_VAL     8'h00   // recipient is the console
`define MAPLE_CMD_VAL       8'h08   // data transfer reply
`define MAPLE_FUNC_VAL      8'h01   // controller function
`define MAPLE_TRIG_FULL     8'hFF   // analog trigger fully pressed

// hotkey patterns, buttons are active low
`define MAPLE_HOT_X         8'hFB
`define MAPLE_HOT_Y         8'hFD
`define MAPLE_HOT_A_START   8'hF3
`define MAPLE_HOT_B_START   8'hF5

// byte positions within the frame
`define MAPLE_POS_WORDS     8'd0
`define MAPLE_POS_RECIP     8'd2
`define MAPLE_POS_CMD       8'd3
`define MAPLE_POS_FUNC      8'd4
`define MAPLE_POS_LTRIG     8'd8
`define MAPLE_POS_RTRIG     8'd9
`define MAPLE_POS_BTN_HI    8'd10   // y and x
`define MAPLE_POS_BTN_LO    8'd11   // b, a, start and dpad

// controller_data bit indices
`define MAPLE_CD_VALID      0
`define MAPLE_CD_DEFRES     1
`define MAPLE_CD_OSD        2
`define MAPLE_CD_LTRIG      3
`define MAPLE_CD_RTRIG      4
`define MAPLE_CD_Y          5
`define MAPLE_CD_X          6
`define MAPLE_CD_B          7
`define MAPLE_CD_A          8
`define MAPLE_CD_START      9
`define MAPLE_CD_UP         10
`define MAPLE_CD_DOWN       11
`define MAPLE_CD_LEFT       12
`define MAPLE_CD_RIGHT      13

// index into button_bits_t for a controller_data bit
`define MAPLE_BTN_IDX(cd_bit) ((cd_bit) - `MAPLE_CD_LTRIG)

// APB register map
`define MAPLE_ADDR_STATE    4'h0
`define MAPLE_ADDR_GOOD     4'h4
`define MAPLE_ADDR_REJECT   4'h8

`endif

/* src/maple_button_capture.sv */
`timescale 1ns/1ps
`include "maple_settings.svh"

// pulls triggers and buttons out of the payload and spots the hotkeys
module maple_button_capture import maple_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    maple_byte_if.sink   rx,
    output button_bits_t buttons,
    output logic         osd_hit,
    output logic         defres_hit
);

    // one bit per payload byte that matched the hotkey
    logic [3:0] osd_cond;       // full triggers, X, A+start
    logic [3:0] defres_cond;    // full triggers, Y, B+start

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            buttons     <= '0;
            osd_cond    <= '0;
            defres_cond <= '0;
        end else if (rx.frame_start) begin
            buttons     <= '0;
            osd_cond    <= '0;
            defres_cond <= '0;
        end else if (rx.byte_valid) begin
            case (rx.pos)
                `MAPLE_POS_LTRIG: begin
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_LTRIG)] <= (rx.data == `MAPLE_TRIG_FULL);
                    osd_cond[0]    <= (rx.data == `MAPLE_TRIG_FULL);
                    defres_cond[0] <= (rx.data == `MAPLE_TRIG_FULL);
                end
                `MAPLE_POS_RTRIG: begin
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_RTRIG)] <= (rx.data == `MAPLE_TRIG_FULL);
                    osd_cond[1]    <= (rx.data == `MAPLE_TRIG_FULL);
                    defres_cond[1] <= (rx.data == `MAPLE_TRIG_FULL);
                end
                `MAPLE_POS_BTN_HI: begin
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_Y)] <= ~rx.data[1];
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_X)] <= ~rx.data[2];
                    osd_cond[2]    <= (rx.data == `MAPLE_HOT_X);   // X alone
                    defres_cond[2] <= (rx.data == `MAPLE_HOT_Y);   // Y alone
                end
                `MAPLE_POS_BTN_LO: begin
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_B)]     <= ~rx.data[1];
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_A)]     <= ~rx.data[2];
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_START)] <= ~rx.data[3];
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_UP)]    <= ~rx.data[4];
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_DOWN)]  <= ~rx.data[5];
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_LEFT)]  <= ~rx.data[6];
                    buttons[`MAPLE_BTN_IDX(`MAPLE_CD_RIGHT)] <= ~rx.data[7];
                    osd_cond[3]    <= (rx.data == `MAPLE_HOT_A_START);
                    defres_cond[3] <= (rx.data == `MAPLE_HOT_B_START);
                end
                default: begin
                    // header and other payload bytes
                end
            endcase
        end
    end

    // all four bytes must match
    assign osd_hit    = &osd_cond;
    assign defres_hit = &defres_cond;

    a_one_hotkey: assert property (
        @(posedge clk) disable iff (reset) !(osd_hit && defres_hit)
    ) else $error("both hotkeys detected in one frame");

endmodule

/* src/maple_byte_if.sv */
`timescale 1ns/1ps

// byte stream from the line receiver to the decoders
interface maple_byte_if import maple_pkg::*; ();

    maple_byte_t data;          // received byte
    byte_pos_t   pos;           // position of data in the frame
    logic        byte_valid;    // one cycle per byte
    logic        frame_start;   // start pattern recognized
    logic        frame_end;     // end pattern recognized

    modport source (
        output data,
        output pos,
        output byte_valid,
        output frame_start,
        output frame_end
    );

    modport sink (
        input data,
        input pos,
        input byte_valid,
        input frame_start,
        input frame_end
    );

endinterface

/* src/maple_ctrl_regs.sv */
`timescale 1ns/1ps
`include "maple_settings.svh"

// controller state and frame counters, read over APB
module maple_ctrl_regs import maple_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    maple_byte_if.sink       rx,
    input  logic             header_ok,
    input  logic             osd_hit,
    input  logic             defres_hit,
    input  button_bits_t     buttons,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [3:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output controller_data_t controller_data
);

    controller_data_t state_q;
    count_t           good_cnt;
    count_t           reject_cnt;
    logic [31:0]      rd_data;
    logic             rd_err;

    // frame result, decoders are settled when frame_end pulses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q    <= '0;
            good_cnt   <= '0;
            reject_cnt <= '0;
        end else if (rx.frame_end) begin
            if (header_ok) begin
                state_q[`MAPLE_CD_VALID]                 <= 1'b1;
                state_q[`MAPLE_CD_DEFRES]                <= defres_hit;
                state_q[`MAPLE_CD_OSD]                   <= osd_hit;
                state_q[`MAPLE_CD_RIGHT:`MAPLE_CD_LTRIG] <= buttons;
                good_cnt <= good_cnt + 16'd1;
            end else begin
                reject_cnt <= reject_cnt + 16'd1;   // state kept as is
            end
        end
    end

    assign controller_data = state_q;
    assign pready          = 1'b1;  // no wait states

    // read decode, registers are read only
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (paddr)
            `MAPLE_ADDR_STATE:  rd_data = 32'(state_q);
            `MAPLE_ADDR_GOOD:   rd_data = 32'(good_cnt);
            `MAPLE_ADDR_REJECT: rd_data = 32'(reject_cnt);
            default:            rd_err  = 1'b1;
        endcase
        if (pwrite) begin
            rd_data = '0;
            rd_err  = 1'b1;
        end
    end

    // loaded in the setup phase so the access phase sees it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (psel && !penable) begin
            prdata  <= rd_data;
            pslverr <= rd_err;
        end else if (!psel) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset) $rose(penable) |-> psel
    ) else $error("penable rose without psel");

    a_wdata_known: assert property (
        @(posedge clk) disable iff (reset) (psel && penable && pwrite) |-> !$isunknown(pwdata)
    ) else $error("unknown pwdata in write access");

endmodule

/* src/maple_header_check.sv */
`timescale 1ns/1ps
`include "maple_settings.svh"

// decides whether the current frame is a controller data reply
module maple_header_check (
    input  logic       clk,
    input  logic       reset,
    maple_byte_if.sink rx,
    output logic       header_ok
);

    // one flag per checked header byte
    logic words_ok;
    logic recip_ok;
    logic cmd_ok;
    logic func_ok;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            words_ok <= 1'b0;
            recip_ok <= 1'b0;
            cmd_ok   <= 1'b0;
            func_ok  <= 1'b0;
        end else if (rx.frame_start) begin
            words_ok <= 1'b0;
            recip_ok <= 1'b0;
            cmd_ok   <= 1'b0;
            func_ok  <= 1'b0;
        end else if (rx.byte_valid) begin
            case (rx.pos)
                `MAPLE_POS_WORDS: begin
                    words_ok <= (rx.data == `MAPLE_WORDS_VAL);
                end
                `MAPLE_POS_RECIP: begin
                    recip_ok <= (rx.data == `MAPLE_RECIP_VAL);
                end
                `MAPLE_POS_CMD: begin
                    cmd_ok <= (rx.data == `MAPLE_CMD_VAL);
                end
                `MAPLE_POS_FUNC: begin
                    func_ok <= (rx.data == `MAPLE_FUNC_VAL);
                end
                default: begin
                    // sender address and payload not checked here
                end
            endcase
        end
    end

    assign header_ok = words_ok & recip_ok & cmd_ok & func_ok;

endmodule

/* src/maple_line_rx.sv */
`timescale 1ns/1ps

// Maple line receiver, passive.
// Waveform expected on the pins, each level held for 4 clocks or more:
//   start  both high, pin1 falls, pin5 falls four times, pin1 rises
//   data   bits MSB first, the first bit of each byte is clocked by pin1
//          pin1 clock: pin5 takes the bit, pin1 falls, pin5 goes high
//          pin5 clock: pin1 takes the bit, pin5 falls, pin1 goes high
//   end    pin5 low, pin1 falls twice, then both lines high
// A line only falls when it acts as a clock, so a second pin1 fall
// without a pin5 fall in between marks the end pattern.
module maple_line_rx import maple_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         pin1,
    input  logic         pin5,
    maple_byte_if.source rx
);

    logic        p1_meta, p1_sync, p1_prev;
    logic        p5_meta, p5_sync, p5_prev;
    logic        p1_fall, p1_rise, p5_fall;

    rx_state_t   state;
    logic [2:0]  start_falls;   // pin5 falls during start
    logic [2:0]  bit_cnt;
    logic        clk_on_p1;     // next bit is clocked by pin1
    logic        bit_take;
    logic        bit_val;
    maple_byte_t shift_q;
    logic        byte_done;     // eighth bit shifted in
    logic        end_stage;

    // two flop synchronizers plus one for edge detection
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p1_meta <= 1'b1;
            p1_sync <= 1'b1;
            p1_prev <= 1'b1;
            p5_meta <= 1'b1;
            p5_sync <= 1'b1;
            p5_prev <= 1'b1;
        end else begin
            p1_meta <= pin1;
            p1_sync <= p1_meta;
            p1_prev <= p1_sync;
            p5_meta <= pin5;
            p5_sync <= p5_meta;
            p5_prev <= p5_sync;
        end
    end

    assign p1_fall = p1_prev & ~p1_sync;
    assign p1_rise = ~p1_prev & p1_sync;
    assign p5_fall = p5_prev & ~p5_sync;

    assign bit_take = (state == rx_data) && (clk_on_p1 ? p1_fall : p5_fall);
    assign bit_val  = clk_on_p1 ? p5_sync : p1_sync;   // the other line holds the bit

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= rx_idle;
            start_falls    <= 3'd0;
            bit_cnt        <= 3'd0;
            clk_on_p1      <= 1'b1;
            byte_done      <= 1'b0;
            end_stage      <= 1'b0;
            rx.pos         <= '0;
            rx.byte_valid  <= 1'b0;
            rx.frame_start <= 1'b0;
            rx.frame_end   <= 1'b0;
        end else begin
            byte_done      <= 1'b0;
            end_stage      <= 1'b0;
            rx.frame_start <= 1'b0;
            rx.byte_valid  <= byte_done;
            rx.frame_end   <= end_stage;

            if (rx.byte_valid && rx.pos != 8'hFF) begin
                rx.pos <= rx.pos + 8'd1;
            end

            case (state)
                rx_idle: begin
                    if (p1_fall && p5_sync) begin
                        state       <= rx_start_pattern;
                        start_falls <= 3'd0;
                    end
                end
                rx_start_pattern: begin
                    if (p5_fall && start_falls != 3'd7) begin
                        start_falls <= start_falls + 3'd1;
                    end
                    if (p1_rise) begin
                        if (start_falls == 3'd4) begin
                            state          <= rx_data;
                            rx.frame_start <= 1'b1;
                            rx.pos         <= '0;
                            bit_cnt        <= 3'd0;
                            clk_on_p1      <= 1'b1;
                        end else begin
                            state <= rx_idle;   // not a start pattern
                        end
                    end
                end
                rx_data: begin
                    if (bit_take) begin
                        bit_cnt   <= bit_cnt + 3'd1;
                        clk_on_p1 <= ~clk_on_p1;
                        byte_done <= (bit_cnt == 3'd7);
                    end else if (!clk_on_p1 && p1_fall && !p5_sync) begin
                        // second pin1 fall with pin5 low, partial byte dropped
                        state <= rx_end_pattern;
                    end
                end
                rx_end_pattern: begin
                    if (p1_rise) begin
                        state     <= rx_idle;
                        end_stage <= 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (bit_take) begin
            shift_q <= {shift_q[6:0], bit_val};
        end
        if (byte_done) begin
            rx.data <= shift_q;
        end
    end

    a_byte_not_at_end: assert property (
        @(posedge clk) disable iff (reset) !(rx.byte_valid && rx.frame_end)
    ) else $error("byte_valid and frame_end in the same cycle");

endmodule

/* src/maple_pkg.sv */
package maple_pkg;

    // one byte as shifted in from the pins
    typedef logic [7:0] maple_byte_t;

    // byte index within a frame, sticks at 255
    typedef logic [7:0] byte_pos_t;

    // published controller state
    // bit layout is given by the MAPLE_CD_* macros
    typedef logic [13:0] controller_data_t;

    // ltrigger in bit 0 up to right in bit 10, active high
    typedef logic [10:0] button_bits_t;

    typedef logic [15:0] count_t;   // frame counter, wraps

    // line receiver states
    typedef enum logic [1:0] {
        rx_idle,            // both lines high
        rx_start_pattern,   // pin1 low, counting pin5 falls
        rx_data,            // shifting bits
        rx_end_pattern      // waiting for pin1 to come back high
    } rx_state_t;

endpackage

/* src/maple_top.sv */
`timescale 1ns/1ps

// passive Maple bus controller decoder with APB readout
module maple_top import maple_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             pin1,
    input  logic             pin5,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [3:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output controller_data_t controller_data
);

    logic         header_ok;
    logic         osd_hit;
    logic         defres_hit;
    button_bits_t buttons;

    maple_byte_if rx_bus ();

    maple_line_rx u_line_rx (
        .clk   (clk),
        .reset (reset),
        .pin1  (pin1),
        .pin5  (pin5),
        .rx    (rx_bus)
    );

    maple_header_check u_header_check (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx_bus),
        .header_ok (header_ok)
    );

    maple_button_capture u_button_capture (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx_bus),
        .buttons    (buttons),
        .osd_hit    (osd_hit),
        .defres_hit (defres_hit)
    );

    maple_ctrl_regs u_ctrl_regs (
        .clk             (clk),
        .reset           (reset),
        .rx              (rx_bus),
        .header_ok       (header_ok),
        .osd_hit         (osd_hit),
        .defres_hit      (defres_hit),
        .buttons         (buttons),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .controller_data (controller_data)
    );

endmodule

/* tb.f */
+incdir+include
+incdir+dv
src/maple_pkg.sv
src/maple_byte_if.sv
src/maple_line_rx.sv
src/maple_header_check.sv
src/maple_button_capture.sv
src/maple_ctrl_regs.sv
src/maple_top.sv
dv/maple_tb.sv
